/* hex_formatter.sv */
`timescale 1ns/1ns

module hex_formatter (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               trigger,
    input  uart_pkg::hex_val_t hex_val,
    input  logic               hex_pop,
    output uart_pkg::byte_t    hex_char,
    output logic               hex_pending,
    output logic               hex_busy
);
    import uart_pkg::*;

    hex_val_t             val_q;    // value latched on the trigger
    logic [HEX_IDX_W-1:0] idx_q;    // current character in the frame
    logic                 busy_q;
    logic [3:0]           nib;      // nibble for the current digit

    // 0..9 then upper case A..F
    function automatic byte_t nib_to_ascii(input logic [3:0] n);
        if (n < 4'd10) begin
            return ASCII_0 + byte_t'(n);
        end
        return ASCII_A + byte_t'(n - 4'd10);
    endfunction

    assign hex_busy    = busy_q;
    assign hex_pending = busy_q;    // a character is always ready while a frame is open

    // most significant nibble first
    always_comb begin
        case (idx_q)
            HEX_IDX_W'(0): nib = val_q[15:12];
            HEX_IDX_W'(1): nib = val_q[11:8];
            HEX_IDX_W'(2): nib = val_q[7:4];
            default:       nib = val_q[3:0];
        endcase
    end

    always_comb begin
        case (idx_q)
            HEX_IDX_W'(4): hex_char = ASCII_CR;
            HEX_IDX_W'(5): hex_char = ASCII_LF;
            default:       hex_char = nib_to_ascii(nib);
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (!busy_q) begin
            if (trigger) begin      // trigger while busy is ignored
                busy_q <= 1'b1;
                idx_q  <= '0;
            end
        end else if (hex_pop) begin
            if (idx_q == HEX_IDX_W'(HEX_FRAME_LEN - 1)) begin
                busy_q <= 1'b0;     // line feed taken, frame done
                idx_q  <= '0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trigger && !busy_q) begin
            val_q <= hex_val;
        end
    end

    a_pop_pending: assert property (@(posedge clk) disable iff (!rst_n)
        hex_pop |-> hex_pending);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_uart_echo_top \
    -f uart_echo_top.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || echo "build or simulation returned an error"
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* rx_fifo.sv */
`timescale 1ns/1ns

module rx_fifo (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  uart_pkg::byte_t push_data,
    input  logic            pop,
    output uart_pkg::byte_t pop_data,
    output logic            not_empty,
    output logic            overrun
);
    import uart_pkg::*;

    byte_t                 mem_q [RX_FIFO_DEPTH];  // circular storage
    logic [RX_FIFO_AW-1:0] wr_ptr_q;
    logic [RX_FIFO_AW-1:0] rd_ptr_q;
    fifo_cnt_t             cnt_q;                  // fill level
    logic                  full;
    logic                  do_push;
    logic                  do_pop;

    assign full      = (cnt_q == fifo_cnt_t'(RX_FIFO_DEPTH));
    assign not_empty = (cnt_q != '0);
    assign do_push   = push && !full;       // push into a full queue is lost
    assign do_pop    = pop && not_empty;
    assign pop_data  = mem_q[rd_ptr_q];     // oldest byte, shown without a pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            overrun  <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;   // wraps at the power-of-two depth
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   cnt_q <= cnt_q + 3'd1;
                2'b01:   cnt_q <= cnt_q - 3'd1;
                default: cnt_q <= cnt_q;       // none or both
            endcase
            if (push && full) begin
                overrun <= 1'b1;               // sticky until reset
            end
        end
    end

    a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
        cnt_q <= fifo_cnt_t'(RX_FIFO_DEPTH));

    // the arbiter only pops after it has seen data
    a_no_empty_pop: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> not_empty);

endmodule

/* tb_uart_echo_top.sv */
`timescale 1ns/1ns

module tb_uart_echo_top;
    import uart_pkg::*;

    localparam int BIT_CYC     = 16;      // baud_div used by every test
    localparam int TIMEOUT_CYC = 20000;   // about 60 frames of 160 cycles, doubled
    localparam int QUIET_CYC   = 400;     // longer than two frames on the line

    logic      clk;
    logic      rst_n;
    baud_div_t baud_div;
    logic      rx_pin;
    logic      trigger;
    hex_val_t  hex_val;
    logic      tx_pin;
    logic      hex_busy;
    logic      overrun;
    logic      frame_err;

    byte_t  seen_q[$];       // bytes decoded from tx_pin
    byte_t  exp_q[$];        // bytes still expected, oldest first
    byte_t  sent[10];        // overrun burst, kept for the order check
    bit     check_en;        // checker owns seen_q while set
    int     got_cnt;         // bytes compared so far
    int     errors;
    int     tests;
    int     ferr_cnt = 0;    // frame_err pulses seen
    int     cycles   = 0;
    integer seed;

    uart_echo_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_div  (baud_div),
        .rx_pin    (rx_pin),
        .trigger   (trigger),
        .hex_val   (hex_val),
        .tx_pin    (tx_pin),
        .hex_busy  (hex_busy),
        .overrun   (overrun),
        .frame_err (frame_err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected frame character: msb nibble first, then cr and lf
    function automatic byte_t hex_frame_char(input hex_val_t value, input int index);
        logic [3:0] nib;
        if (index == 4) return 8'h0D;
        if (index == 5) return 8'h0A;
        nib = value[15 - 4 * index -: 4];
        if (nib < 4'd10) return 8'h30 + {4'h0, nib};   // '0'..'9'
        return 8'h37 + {4'h0, nib};                    // 'A' sits at 0x37 + 10
    endfunction

    function automatic byte_t rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic report_value(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
        $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // one 8N1 frame on rx_pin with a chosen stop level
    task automatic send_serial(input byte_t b, input logic stop_lvl);
        @(negedge clk);
        rx_pin = 1'b0;            // start bit
        wait_cycles(BIT_CYC);
        for (int i = 0; i < 8; i++) begin
            rx_pin = b[i];        // lsb first
            wait_cycles(BIT_CYC);
        end
        rx_pin = stop_lvl;
        wait_cycles(BIT_CYC);
        rx_pin = 1'b1;
    endtask

    task automatic pulse_trigger(input hex_val_t v);
        @(negedge clk);
        hex_val = v;
        trigger = 1'b1;
        @(negedge clk);
        trigger = 1'b0;
    endtask

    task automatic expect_hex(input hex_val_t v);
        for (int i = 0; i < HEX_FRAME_LEN; i++) begin
            exp_q.push_back(hex_frame_char(v, i));
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - err_before);
    endtask

    // tx_pin decoder, samples near each bit centre on the falling edge
    initial begin : tx_monitor
        byte_t b;
        forever begin
            @(negedge clk);
            if (rst_n === 1'b1 && tx_pin === 1'b0) begin
                wait_cycles(BIT_CYC / 2 - 1);
                if (tx_pin !== 1'b0) begin
                    $display("t=%0t start bit on tx_pin did not stay low", $time);
                    errors++;
                end
                for (int i = 0; i < 8; i++) begin
                    wait_cycles(BIT_CYC);
                    b[i] = tx_pin;
                end
                wait_cycles(BIT_CYC);
                if (tx_pin !== 1'b1) begin
                    $display("t=%0t stop bit on tx_pin was low", $time);
                    errors++;
                end
                seen_q.push_back(b);
            end
        end
    end

    // in-order compare of decoded bytes against exp_q
    always @(negedge clk) begin : compare_bytes
        byte_t b;
        byte_t e;
        if (check_en && seen_q.size() != 0) begin
            b = seen_q.pop_front();
            got_cnt++;
            if (exp_q.size() == 0) begin
                $display("t=%0t byte %02h on tx_pin was not expected", $time, b);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (b !== e) report_value("tx_pin byte", b, e);
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n === 1'b1 && frame_err === 1'b1) ferr_cnt++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin : main
        int       e0;
        int       n;
        int       j;
        int       f0;
        byte_t    b;
        hex_val_t v;
        seed     = 32'hbe03b120;
        rst_n    = 1'b0;
        rx_pin   = 1'b1;
        trigger  = 1'b0;
        hex_val  = '0;
        baud_div = baud_div_t'(BIT_CYC);
        check_en = 1'b1;
        got_cnt  = 0;
        errors   = 0;
        tests    = 0;
        wait_cycles(10);
        rst_n = 1'b1;

        e0 = errors;   // idle state after reset
        if (tx_pin !== 1'b1) report_value("tx_pin", tx_pin, 1);
        if (hex_busy !== 1'b0) report_value("hex_busy", hex_busy, 0);
        if (overrun !== 1'b0) report_value("overrun", overrun, 0);
        if (frame_err !== 1'b0) report_value("frame_err", frame_err, 0);
        n = 0;         // cycles with tx_pin off its idle level
        for (int k = 0; k < 200; k++) begin
            wait_cycles(1);
            if (tx_pin !== 1'b1) n++;
        end
        if (n != 0 || seen_q.size() != 0 || got_cnt != 0) begin
            $display("t=%0t tx_pin left idle for %0d cycles after reset", $time, n);
            errors++;
        end
        end_test("reset", e0);

        e0 = errors;   // plain echo with gaps
        n  = got_cnt + 8;
        for (int k = 0; k < 8; k++) begin
            b = rand_byte();
            exp_q.push_back(b);
            send_serial(b, 1'b1);
            wait_cycles(40);
        end
        wait (got_cnt >= n);
        end_test("echo", e0);

        e0 = errors;   // hex frame, second trigger ignored
        v  = {rand_byte(), rand_byte()};
        n  = got_cnt + HEX_FRAME_LEN;
        expect_hex(v);
        pulse_trigger(v);
        if (hex_busy !== 1'b1) report_value("hex_busy", hex_busy, 1);
        wait_cycles(100);
        pulse_trigger(~v);
        wait (got_cnt >= n);
        wait_cycles(QUIET_CYC);
        if (got_cnt != n) report_value("frame bytes", 16'(got_cnt - n + HEX_FRAME_LEN), 6);
        if (hex_busy !== 1'b0) report_value("hex_busy", hex_busy, 0);
        end_test("hex frame", e0);

        e0 = errors;   // hex frame first, echoes queue behind it
        v  = {rand_byte(), rand_byte()};
        n  = got_cnt + HEX_FRAME_LEN + 3;
        expect_hex(v);
        pulse_trigger(v);
        for (int k = 0; k < 3; k++) begin
            b = rand_byte();
            exp_q.push_back(b);
            send_serial(b, 1'b1);
        end
        wait (got_cnt >= n);
        end_test("mixed", e0);

        e0 = errors;   // low stop bit is dropped
        f0 = ferr_cnt;
        send_serial(rand_byte(), 1'b0);
        wait_cycles(QUIET_CYC);
        if (ferr_cnt != f0 + 1) report_value("frame_err pulses", 16'(ferr_cnt - f0), 1);
        b = rand_byte();
        n = got_cnt + 1;
        exp_q.push_back(b);
        send_serial(b, 1'b1);
        wait (got_cnt >= n);
        end_test("framing error", e0);

        e0 = errors;   // burst behind a hex frame overflows the queue
        check_en = 1'b0;
        if (overrun !== 1'b0) report_value("overrun", overrun, 0);
        v = {rand_byte(), rand_byte()};
        pulse_trigger(v);
        for (int k = 0; k < 10; k++) begin
            sent[k] = rand_byte();
            send_serial(sent[k], 1'b1);
        end
        do begin
            n = seen_q.size();
            wait_cycles(QUIET_CYC);
        end while (seen_q.size() != n);
        if (overrun !== 1'b1) report_value("overrun", overrun, 1);
        if (seen_q.size() < HEX_FRAME_LEN) begin
            $display("t=%0t hex frame missing in the overrun burst", $time);
            errors++;
        end
        for (int i = 0; i < HEX_FRAME_LEN && seen_q.size() != 0; i++) begin
            b = seen_q.pop_front();
            if (b !== hex_frame_char(v, i)) report_value("tx_pin byte", b, hex_frame_char(v, i));
        end
        n = seen_q.size();   // echoes left after the frame
        j = 0;
        while (seen_q.size() != 0) begin
            b = seen_q.pop_front();
            while (j < 10 && sent[j] !== b) j++;
            if (j == 10) begin
                $display("t=%0t echo %02h is not in send order", $time, b);
                errors++;
            end else begin
                j++;
            end
        end
        if (10 - n > RX_FIFO_DEPTH + 1) report_value("dropped bytes", 16'(10 - n), 5);
        end_test("overrun", e0);

        $display("%0d tests, %0d bytes compared, %0d errors", tests, got_cnt, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* tx_arbiter.sv */
`timescale 1ns/1ns

module tx_arbiter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            hex_pending,
    input  uart_pkg::byte_t hex_char,
    input  logic            fifo_not_empty,
    input  uart_pkg::byte_t fifo_data,
    input  logic            tx_busy,
    output logic            hex_pop,
    output logic            fifo_pop,
    output logic            tx_start,
    output uart_pkg::byte_t tx_data
);
    import uart_pkg::*;

    logic hold_q;      // start issued, tx_busy not seen yet
    logic pick_hex;    // hex source has fixed priority
    logic issue;

    assign pick_hex = hex_pending;
    assign issue    = !tx_busy && !hold_q && (hex_pending || fifo_not_empty);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hex_pop  <= 1'b0;
            fifo_pop <= 1'b0;
            tx_start <= 1'b0;
            hold_q   <= 1'b0;
        end else begin
            hex_pop  <= issue && pick_hex;     // registered grant
            fifo_pop <= issue && !pick_hex;
            tx_start <= issue;                 // same cycle as the pop
            if (issue) begin
                hold_q <= 1'b1;
            end else if (tx_busy) begin
                hold_q <= 1'b0;                // transmitter has taken over
            end
        end
    end

    // character captured with the grant, before the source advances
    always_ff @(posedge clk) begin
        if (issue) begin
            tx_data <= pick_hex ? hex_char : fifo_data;
        end
    end

    a_one_pop: assert property (@(posedge clk) disable iff (!rst_n)
        !(hex_pop && fifo_pop));

endmodule

/* uart_echo_top.f */
uart_pkg.sv
uart_rx.sv
rx_fifo.sv
hex_formatter.sv
tx_arbiter.sv
uart_tx.sv
uart_echo_top.sv
tb_uart_echo_top.sv

/* uart_echo_top.sv */
`timescale 1ns/1ns

module uart_echo_top (
    input  logic                clk,
    input  logic                rst_n,
    input  uart_pkg::baud_div_t baud_div,
    input  logic                rx_pin,
    input  logic                trigger,
    input  uart_pkg::hex_val_t  hex_val,
    output logic                tx_pin,
    output logic                hex_busy,
    output logic                overrun,
    output logic                frame_err
);
    import uart_pkg::*;

    byte_t rx_byte;         // receiver to queue
    logic  rx_strobe;
    byte_t fifo_data;       // oldest queued byte
    logic  fifo_not_empty;
    logic  fifo_pop;
    byte_t hex_char;        // current frame character
    logic  hex_pending;
    logic  hex_pop;
    logic  tx_start;        // arbiter to transmitter
    byte_t tx_data;
    logic  tx_busy;

    uart_rx rx_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .baud_div  (baud_div),
        .rx_pin    (rx_pin),
        .rx_byte   (rx_byte),
        .rx_strobe (rx_strobe),
        .frame_err (frame_err)
    );

    rx_fifo fifo_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (rx_strobe),
        .push_data (rx_byte),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .not_empty (fifo_not_empty),
        .overrun   (overrun)
    );

    hex_formatter hex_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .trigger     (trigger),
        .hex_val     (hex_val),
        .hex_pop     (hex_pop),
        .hex_char    (hex_char),
        .hex_pending (hex_pending),
        .hex_busy    (hex_busy)
    );

    tx_arbiter arb_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .hex_pending    (hex_pending),
        .hex_char       (hex_char),
        .fifo_not_empty (fifo_not_empty),
        .fifo_data      (fifo_data),
        .tx_busy        (tx_busy),
        .hex_pop        (hex_pop),
        .fifo_pop       (fifo_pop),
        .tx_start       (tx_start),
        .tx_data        (tx_data)
    );

    uart_tx tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .baud_div (baud_div),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_pin   (tx_pin),
        .tx_busy  (tx_busy)
    );

endmodule

/* uart_pkg.sv */
package uart_pkg;

    // character and value widths
    typedef logic [7:0]  byte_t;      // one serial character
    typedef logic [15:0] hex_val_t;   // debug value, printed as four hex digits
    typedef logic [15:0] baud_div_t;  // bit period in clk cycles
    typedef logic [2:0]  fifo_cnt_t;  // echo queue fill level 0..4

    localparam int DATA_BITS     = 8;                       // 8N1 framing
    localparam int RX_FIFO_DEPTH = 4;                       // echo queue capacity in bytes
    localparam int RX_FIFO_AW    = $clog2(RX_FIFO_DEPTH);   // pointer width
    localparam int HEX_FRAME_LEN = 6;                       // four digits then cr and lf
    localparam int HEX_IDX_W     = $clog2(HEX_FRAME_LEN);   // character index width

    // ascii codes used by the hex formatter
    localparam byte_t ASCII_0  = 8'h30;
    localparam byte_t ASCII_A  = 8'h41;
    localparam byte_t ASCII_CR = 8'h0D;
    localparam byte_t ASCII_LF = 8'h0A;

    // receiver fsm
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    // transmitter fsm
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

endpackage

/* uart_rx.sv */
`timescale 1ns/1ns

module uart_rx (
    input  logic                clk,
    input  logic                rst_n,
    input  uart_pkg::baud_div_t baud_div,
    input  logic                rx_pin,
    output uart_pkg::byte_t     rx_byte,
    output logic                rx_strobe,
    output logic                frame_err
);
    import uart_pkg::*;

    logic [2:0] sync_q;     // [1:0] two-flop synchronizer, [2] previous synced level
    logic       rx_s;       // synchronized line
    logic       rx_fall;    // falling edge on the synced line
    rx_state_t  state_q;
    baud_div_t  cnt_q;      // counts down to the next bit centre
    logic [2:0] bit_q;      // data bit index
    byte_t      shift_q;    // lsb arrives first

    assign rx_s    = sync_q[1];
    assign rx_fall = sync_q[2] & ~sync_q[1];
    assign rx_byte = shift_q;   // stable while rx_strobe is high

    // line idles high, so the synchronizer resets to ones
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[1:0], rx_pin};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q   <= RX_IDLE;
            cnt_q     <= '0;
            bit_q     <= '0;
            rx_strobe <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;  // both strobes are single cycle
            frame_err <= 1'b0;
            case (state_q)
                RX_IDLE: begin
                    if (rx_fall) begin
                        state_q <= RX_START;
                        cnt_q   <= (baud_div >> 1) - 16'd1;  // half a bit to the centre
                    end
                end
                RX_START: begin
                    if (cnt_q != '0) begin
                        cnt_q <= cnt_q - 16'd1;
                    end else if (!rx_s) begin  // start bit still low at its centre
                        state_q <= RX_DATA;
                        cnt_q   <= baud_div - 16'd1;
                        bit_q   <= '0;
                    end else begin
                        state_q <= RX_IDLE;    // glitch, not a real start bit
                    end
                end
                RX_DATA: begin
                    if (cnt_q != '0) begin
                        cnt_q <= cnt_q - 16'd1;
                    end else begin
                        cnt_q <= baud_div - 16'd1;
                        bit_q <= bit_q + 3'd1;
                        if (bit_q == 3'(DATA_BITS - 1)) begin
                            state_q <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (cnt_q != '0) begin
                        cnt_q <= cnt_q - 16'd1;
                    end else begin
                        state_q   <= RX_IDLE;
                        rx_strobe <= rx_s;    // good stop bit, byte is valid
                        frame_err <= ~rx_s;   // low stop bit drops the byte
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    // data bits shift in at each bit centre
    always_ff @(posedge clk) begin
        if (state_q == RX_DATA && cnt_q == '0) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
    end

    a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rx_strobe && frame_err));

endmodule

/* uart_tx.sv */
`timescale 1ns/1ns

module uart_tx (
    input  logic                clk,
    input  logic                rst_n,
    input  uart_pkg::baud_div_t baud_div,
    input  logic                tx_start,
    input  uart_pkg::byte_t     tx_data,
    output logic                tx_pin,
    output logic                tx_busy
);
    import uart_pkg::*;

    tx_state_t  state_q;
    baud_div_t  cnt_q;      // cycles left in the current bit
    logic [2:0] bit_q;      // data bit index
    byte_t      shift_q;    // bit 0 is the one on the line

    assign tx_busy = (state_q != TX_IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= TX_IDLE;
            cnt_q   <= '0;
            bit_q   <= '0;
            tx_pin  <= 1'b1;   // idle line is high
        end else begin
            case (state_q)
                TX_IDLE: begin
                    if (tx_start) begin
                        state_q <= TX_START;
                        cnt_q   <= baud_div - 16'd1;
                        tx_pin  <= 1'b0;             // start bit
                    end
                end
                TX_START: begin
                    if (cnt_q != '0) begin
                        cnt_q <= cnt_q - 16'd1;
                    end else begin
                        state_q <= TX_DATA;
                        cnt_q   <= baud_div - 16'd1;
                        bit_q   <= '0;
                        tx_pin  <= shift_q[0];       // lsb first
                    end
                end
                TX_DATA: begin
                    if (cnt_q != '0) begin
                        cnt_q <= cnt_q - 16'd1;
                    end else begin
                        cnt_q <= baud_div - 16'd1;
                        if (bit_q == 3'(DATA_BITS - 1)) begin
                            state_q <= TX_STOP;
                            tx_pin  <= 1'b1;         // stop bit
                        end else begin
                            bit_q  <= bit_q + 3'd1;
                            tx_pin <= shift_q[1];    // next bit, before the shift lands
                        end
                    end
                end
                TX_STOP: begin
                    if (cnt_q != '0) begin
                        cnt_q <= cnt_q - 16'd1;
                    end else begin
                        state_q <= TX_IDLE;          // line stays high
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == TX_IDLE && tx_start) begin
            shift_q <= tx_data;
        end else if (state_q == TX_DATA && cnt_q == '0) begin
            shift_q <= shift_q >> 1;
        end
    end

    // a start is only legal when idle, and busy follows one cycle later
    a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy ##1 tx_busy);

endmodule
